/* hw/fu_cfg.svh */
`ifndef FU_CFG_SVH
`define FU_CFG_SVH

// data and address width of the core
`define FU_XLEN 32

// link address sits past the delay slot
`define FU_LINK_OFFSET 8

// one-bit logic levels
`define FU_TRUE  1'b1
`define FU_FALSE 1'b0

`endif

/* hw/fu_pkg.sv */
`include "fu_cfg.svh"

package fu_pkg;

    typedef logic [`FU_XLEN-1:0] word_t;
    typedef logic [`FU_XLEN-1:0] pc_t;
    typedef logic [4:0]          reg_addr_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_nor  = 4'd5,
        alu_slt  = 4'd6,
        alu_sltu = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_op_e;

    // zero compare forms look at num1 only
    typedef enum logic [2:0] {
        llu_eq  = 3'd0,
        llu_ne  = 3'd1,
        llu_lez = 3'd2,
        llu_gtz = 3'd3,
        llu_ltz = 3'd4,
        llu_gez = 3'd5
    } llu_op_e;

    typedef enum logic [1:0] {
        exe_alu    = 2'd0,
        exe_mem    = 2'd1,
        exe_branch = 2'd2
    } exe_type_e;

    typedef enum logic [1:0] {
        br_b  = 2'd0,
        br_j  = 2'd1,
        br_jr = 2'd2
    } branch_type_e;

    typedef struct packed {
        pc_t          pc;
        word_t        num1;
        word_t        num2;
        word_t        mem_offset;
        alu_op_e      alu_op;
        llu_op_e      llu_op;
        exe_type_e    exe_type;
        branch_type_e branch_type;
        logic         predict_taken;
        pc_t          predict_pc;
        logic         mem_read_ena;
        logic         mem_write_ena;
        logic         write_reg_need;
        reg_addr_t    write_reg_addr;
    } fu_require_t;

    typedef struct packed {
        logic      mem_read_ena;
        logic      mem_write_ena;
        logic      write_reg_need;
        reg_addr_t write_reg_addr;
        word_t     result;
        word_t     write_data;
        word_t     addr;
    } mem_require_t;

    typedef struct packed {
        logic enable;
        pc_t  pc_new;
    } pc_check_t;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  fu_pkg::word_t   a,
    input  fu_pkg::word_t   b,
    input  fu_pkg::alu_op_e alu_op,
    output fu_pkg::word_t   c
);
    import fu_pkg::*;

    logic [4:0] shamt;

    // mips order takes the amount from a and shifts b
    assign shamt = a[4:0];

    always_comb begin
        case (alu_op)
            alu_add: begin
                c = a + b;
            end
            alu_sub: begin
                c = a - b;
            end
            alu_and: begin
                c = a & b;
            end
            alu_or: begin
                c = a | b;
            end
            alu_xor: begin
                c = a ^ b;
            end
            alu_nor: begin
                c = ~(a | b);
            end
            alu_slt: begin
                c = word_t'($signed(a) < $signed(b));
            end
            alu_sltu: begin
                c = word_t'(a < b);
            end
            alu_sll: begin
                c = b << shamt;
            end
            alu_srl: begin
                c = b >> shamt;
            end
            alu_sra: begin
                c = word_t'($signed(b) >>> shamt);
            end
            default: begin
                c = '0;
            end
        endcase
    end

endmodule

/* hw/llu.sv */
`timescale 1ns/1ps
`include "fu_cfg.svh"

module llu (
    input  fu_pkg::word_t   a,
    input  fu_pkg::word_t   b,
    input  fu_pkg::llu_op_e llu_op,
    output logic            c
);
    import fu_pkg::*;

    logic a_zero;
    logic a_neg;

    assign a_zero = (a == '0);
    // sign bit of a signed a
    assign a_neg  = a[`FU_XLEN-1];

    always_comb begin
        case (llu_op)
            llu_eq:  c = (a == b);
            llu_ne:  c = (a != b);
            llu_lez: c = a_neg | a_zero;
            llu_gtz: c = ~a_neg & ~a_zero;
            llu_ltz: c = a_neg;
            llu_gez: c = ~a_neg;
            default: c = `FU_FALSE;
        endcase
    end

endmodule

/* hw/redirect_check.sv */
`timescale 1ns/1ps
`include "fu_cfg.svh"

module redirect_check (
    input  fu_pkg::fu_require_t req,
    input  logic                taken,
    input  fu_pkg::pc_t         link_pc,
    output fu_pkg::pc_check_t   redirect
);
    import fu_pkg::*;

    logic target_miss;

    // jr target is only known here, so compare it with the guess
    assign target_miss = (req.predict_pc != req.num1);

    always_comb begin
        redirect.enable = `FU_FALSE;
        redirect.pc_new = '0;
        if (req.exe_type == exe_branch) begin
            case (req.branch_type)
                br_b: begin
                    if (taken == `FU_TRUE && req.predict_taken == `FU_FALSE) begin
                        redirect.enable = `FU_TRUE;
                        redirect.pc_new = req.predict_pc;
                    end else if (taken == `FU_FALSE && req.predict_taken == `FU_TRUE) begin
                        // fall through past the delay slot
                        redirect.enable = `FU_TRUE;
                        redirect.pc_new = link_pc;
                    end
                end
                br_j: begin
                    if (req.predict_taken == `FU_FALSE) begin
                        redirect.enable = `FU_TRUE;
                        redirect.pc_new = req.predict_pc;
                    end
                end
                br_jr: begin
                    if (req.predict_taken == `FU_FALSE || target_miss) begin
                        redirect.enable = `FU_TRUE;
                        redirect.pc_new = req.num1;
                    end
                end
                default: begin
                    redirect.enable = `FU_FALSE;
                    redirect.pc_new = '0;
                end
            endcase
        end
    end

endmodule

/* hw/fu.sv */
`timescale 1ns/1ps
`include "fu_cfg.svh"

module fu (
    input  fu_pkg::fu_require_t  req,
    output fu_pkg::mem_require_t mem_req,
    output fu_pkg::pc_check_t    redirect
);
    import fu_pkg::*;

    word_t alu_result;
    logic  llu_result;
    pc_t   link_pc;

    alu alu_i (
        .a      (req.num1),
        .b      (req.num2),
        .alu_op (req.alu_op),
        .c      (alu_result)
    );

    llu llu_i (
        .a      (req.num1),
        .b      (req.num2),
        .llu_op (req.llu_op),
        .c      (llu_result)
    );

    // return address for branch-and-link
    assign link_pc = req.pc + pc_t'(`FU_LINK_OFFSET);

    assign mem_req.mem_read_ena   = req.mem_read_ena;
    assign mem_req.mem_write_ena  = req.mem_write_ena;
    assign mem_req.write_reg_need = req.write_reg_need;
    assign mem_req.write_reg_addr = req.write_reg_addr;
    assign mem_req.result         = (req.exe_type == exe_branch) ? link_pc : alu_result;
    // store data comes from num1
    assign mem_req.write_data     = req.num1;
    // offset(num2) addressing
    assign mem_req.addr           = req.mem_offset + req.num2;

    redirect_check redirect_check_i (
        .req      (req),
        .taken    (llu_result),
        .link_pc  (link_pc),
        .redirect (redirect)
    );

endmodule

/* hw/exec_stage.sv */
`timescale 1ns/1ps
`include "fu_cfg.svh"

module exec_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  fu_pkg::fu_require_t  in_req,
    output logic                 out_valid,
    output fu_pkg::mem_require_t out_req,
    output fu_pkg::pc_check_t    redirect
);
    import fu_pkg::*;

    logic         iss_valid;
    fu_require_t  iss_req;
    mem_require_t fu_mem_req;
    pc_check_t    fu_redirect;
    logic         squash;
    logic         iss_load;

    // a redirect from the issued item kills the wrong-path item behind it
    assign squash   = iss_valid & fu_redirect.enable;
    assign iss_load = in_valid & ~squash;

    // issue register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_valid <= `FU_FALSE;
        end else begin
            iss_valid <= iss_load;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_load) begin
            iss_req <= in_req;
        end
    end

    fu fu_i (
        .req      (iss_req),
        .mem_req  (fu_mem_req),
        .redirect (fu_redirect)
    );

    // result register
    always_ff @(posedge clk) begin
        out_req         <= fu_mem_req;
        redirect.pc_new <= fu_redirect.pc_new;
        if (!rst_n) begin
            out_valid       <= `FU_FALSE;
            redirect.enable <= `FU_FALSE;
        end else begin
            out_valid       <= iss_valid;
            // only a live item may redirect
            redirect.enable <= squash;
        end
    end

endmodule

/* sim/tb_exec_stage.sv */
`timescale 1ns/1ps

module tb_exec_stage;
    import fu_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    fu_require_t  in_req;
    logic         out_valid;
    mem_require_t out_req;
    pc_check_t    redirect;

    fu_require_t vec_req[$];
    logic        vec_valid[$];
    logic        exp_valid[$];
    word_t       exp_result[$];
    word_t       exp_addr[$];
    word_t       exp_wdata[$];
    logic        exp_ren[$];
    pc_t         exp_rpc[$];

    int cycles = 0;
    int cycle_limit = 20;

    exec_stage dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_req   (out_req),
        .redirect  (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, field, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "output mismatch on %s", field);
        end
    endtask

    task automatic read_vectors();
        int          fd;
        int          fields;
        string       line;
        fu_require_t r;
        logic        f_v, f_pt, f_rd, f_wr, f_wn, f_ev, f_ren;
        word_t       f_pc, f_n1, f_n2, f_off, f_ppc, f_res, f_addr, f_wd, f_rpc;
        logic [3:0]  f_alu;
        logic [2:0]  f_llu;
        logic [1:0]  f_exe, f_br;
        logic [4:0]  f_wa;
        fd = $fopen("sim/fu_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file sim/fu_stim.txt");
            $display("STATUS: FAIL");
            $fatal(1, "missing stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_v, f_pc, f_n1, f_n2, f_off, f_alu, f_llu, f_exe, f_br, f_pt, f_ppc,
                    f_rd, f_wr, f_wn, f_wa, f_ev, f_res, f_addr, f_wd, f_ren, f_rpc);
                if (fields != 21) begin
                    $display("stimulus line has %0d fields instead of 21: %s", fields, line);
                    $display("STATUS: FAIL");
                    $fatal(1, "bad stimulus line");
                end
                r.pc             = f_pc;
                r.num1           = f_n1;
                r.num2           = f_n2;
                r.mem_offset     = f_off;
                r.alu_op         = alu_op_e'(f_alu);
                r.llu_op         = llu_op_e'(f_llu);
                r.exe_type       = exe_type_e'(f_exe);
                r.branch_type    = branch_type_e'(f_br);
                r.predict_taken  = f_pt;
                r.predict_pc     = f_ppc;
                r.mem_read_ena   = f_rd;
                r.mem_write_ena  = f_wr;
                r.write_reg_need = f_wn;
                r.write_reg_addr = f_wa;
                vec_req.push_back(r);
                vec_valid.push_back(f_v);
                exp_valid.push_back(f_ev);
                exp_result.push_back(f_res);
                exp_addr.push_back(f_addr);
                exp_wdata.push_back(f_wd);
                exp_ren.push_back(f_ren);
                exp_rpc.push_back(f_rpc);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int i);
        in_valid = vec_valid[i];
        in_req   = vec_req[i];
        // bubbles carry junk operands
        if (!vec_valid[i]) begin
            in_req.pc         = $urandom();
            in_req.num1       = $urandom();
            in_req.num2       = $urandom();
            in_req.mem_offset = $urandom();
            in_req.predict_pc = $urandom();
        end
    endtask

    task automatic check_idle();
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("redirect.enable", 32'(redirect.enable), 32'd0);
    endtask

    task automatic check_vector(input int i);
        check_value("out_valid", 32'(out_valid), 32'(exp_valid[i]));
        check_value("redirect.enable", 32'(redirect.enable), 32'(exp_ren[i]));
        if (exp_valid[i]) begin
            check_value("result", out_req.result, exp_result[i]);
            check_value("addr", out_req.addr, exp_addr[i]);
            check_value("write_data", out_req.write_data, exp_wdata[i]);
            check_value("redirect.pc_new", redirect.pc_new, exp_rpc[i]);
            // control bits pass straight through
            check_value("mem_read_ena", 32'(out_req.mem_read_ena),
                        32'(vec_req[i].mem_read_ena));
            check_value("mem_write_ena", 32'(out_req.mem_write_ena),
                        32'(vec_req[i].mem_write_ena));
            check_value("write_reg_need", 32'(out_req.write_reg_need),
                        32'(vec_req[i].write_reg_need));
            check_value("write_reg_addr", 32'(out_req.write_reg_addr),
                        32'(vec_req[i].write_reg_addr));
        end
    endtask

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run went past %0d clock cycles", cycle_limit);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        int nvec;
        void'($urandom(32'hbb83));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        read_vectors();
        nvec = vec_req.size();
        cycle_limit = nvec + 20;
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        rst_n = 1'b1;
        // results of vector n-2 are visible at the falling edge that drives vector n
        for (int n = 0; n < nvec + 2; n++) begin
            if (n > 0) begin
                @(negedge clk);
            end
            if (n >= 2) begin
                check_vector(n - 2);
            end else begin
                check_idle();
            end
            if (n < nvec) begin
                drive_vector(n);
            end else begin
                in_valid = 1'b0;
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
hw/fu_pkg.sv
hw/alu.sv
hw/llu.sv
hw/redirect_check.sv
hw/fu.sv
hw/exec_stage.sv
sim/tb_exec_stage.sv

/* run.sh */
#!/bin/sh
# builds the exec stage testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f list.f \
        --top-module tb_exec_stage -o tb_exec_stage \
    && ./obj_dir/tb_exec_stage \
    || { echo "simulation failed"; exit 1; }

/* sim/fu_stim.txt */
# v pc num1 num2 offset alu_op llu_op exe br pred_taken pred_pc rd wr wn wa
#   then expected: out_valid result addr write_data redirect_enable redirect_pc
1 00400000 00000005 00000007 00000000 0 0 0 0 0 00000000 0 0 1 08 1 0000000c 00000007 00000005 0 00000000
1 00400004 00000005 00000007 00000000 1 0 0 0 0 00000000 0 0 1 09 1 fffffffe 00000007 00000005 0 00000000
1 00400008 f0f0f0f0 0ff00ff0 00000000 2 0 0 0 0 00000000 0 0 1 0a 1 00f000f0 0ff00ff0 f0f0f0f0 0 00000000
1 0040000c f0f0f0f0 0ff00ff0 00000000 3 0 0 0 0 00000000 0 0 1 0b 1 fff0fff0 0ff00ff0 f0f0f0f0 0 00000000
1 00400010 f0f0f0f0 0ff00ff0 00000000 4 0 0 0 0 00000000 0 0 1 0c 1 ff00ff00 0ff00ff0 f0f0f0f0 0 00000000
1 00400014 f0f0f0f0 0ff00ff0 00000000 5 0 0 0 0 00000000 0 0 1 0d 1 000f000f 0ff00ff0 f0f0f0f0 0 00000000
1 00400018 ffffffff 00000001 00000000 6 0 0 0 0 00000000 0 0 1 0e 1 00000001 00000001 ffffffff 0 00000000
1 0040001c ffffffff 00000001 00000000 7 0 0 0 0 00000000 0 0 1 0f 1 00000000 00000001 ffffffff 0 00000000
1 00400020 00000001 ffffffff 00000000 6 0 0 0 0 00000000 0 0 1 0e 1 00000000 ffffffff 00000001 0 00000000
1 00400024 00000001 ffffffff 00000000 7 0 0 0 0 00000000 0 0 1 0f 1 00000001 ffffffff 00000001 0 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00000000 0 0 0 00 0 00000000 00000000 00000000 0 00000000
1 00400028 00000004 00000003 00000000 8 0 0 0 0 00000000 0 0 1 10 1 00000030 00000003 00000004 0 00000000
1 0040002c 00000024 80000000 00000000 9 0 0 0 0 00000000 0 0 1 11 1 08000000 80000000 00000024 0 00000000
1 00400030 00000004 80000000 00000000 a 0 0 0 0 00000000 0 0 1 12 1 f8000000 80000000 00000004 0 00000000
1 00400040 deadbeef 10000000 00000010 0 0 1 0 0 00000000 1 0 1 09 1 eeadbeef 10000010 deadbeef 0 00000000
1 00400044 12345678 00001000 fffffffc 0 0 1 0 0 00000000 0 1 0 00 1 12346678 00000ffc 12345678 0 00000000
1 00400100 00000005 00000005 00000000 1 0 2 0 1 00400800 0 0 0 00 1 00400108 00000005 00000005 0 00000000
1 00400110 00000005 00000005 00000000 1 1 2 0 0 00400810 0 0 0 00 1 00400118 00000005 00000005 0 00000000
1 00400120 ffffff00 00000077 00000000 1 2 2 0 0 00400820 0 0 0 00 1 00400128 00000077 ffffff00 1 00400820
1 00400124 00000001 00000001 00000000 0 0 0 0 0 00000000 0 0 1 01 0 00000000 00000000 00000000 0 00000000
1 00400130 00000000 00000000 00000000 1 3 2 0 1 00400830 0 0 0 00 1 00400138 00000000 00000000 1 00400138
1 00400134 00000002 00000002 00000000 0 0 0 0 0 00000000 0 0 1 02 0 00000000 00000000 00000000 0 00000000
1 00400140 80000000 00000003 00000000 1 4 2 0 1 00400840 0 0 0 00 1 00400148 00000003 80000000 0 00000000
1 00400150 00000000 00000000 00000000 1 5 2 0 0 00400850 0 0 0 00 1 00400158 00000000 00000000 1 00400850
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00000000 0 0 0 00 0 00000000 00000000 00000000 0 00000000
1 00400160 00000001 00000002 00000000 1 0 2 0 1 00400860 0 0 0 00 1 00400168 00000002 00000001 1 00400168
1 00400164 00000003 00000003 00000000 0 0 0 0 0 00000000 0 0 1 03 0 00000000 00000000 00000000 0 00000000
1 00400170 00000001 00000000 00000000 1 2 2 0 0 00400870 0 0 0 00 1 00400178 00000000 00000001 0 00000000
1 00400180 00000002 00000000 00000000 1 3 2 0 1 00400880 0 0 0 00 1 00400188 00000000 00000002 0 00000000
1 00400190 00000003 00000004 00000000 1 1 2 0 0 00400890 0 0 0 00 1 00400198 00000004 00000003 1 00400890
1 00400194 00000004 00000004 00000000 0 0 0 0 0 00000000 0 0 1 04 0 00000000 00000000 00000000 0 00000000
1 004001a0 00000000 00000000 00000000 1 0 2 1 1 00401000 0 0 1 1f 1 004001a8 00000000 00000000 0 00000000
1 004001b0 00000000 00000000 00000000 1 0 2 1 0 00402000 0 0 1 1f 1 004001b8 00000000 00000000 1 00402000
1 004001b4 00000005 00000005 00000000 0 0 0 0 0 00000000 0 0 1 05 0 00000000 00000000 00000000 0 00000000
1 004001c0 00403000 00000000 00000000 1 0 2 2 1 00403000 0 0 0 00 1 004001c8 00000000 00403000 0 00000000
1 004001d0 00404000 00000000 00000000 1 0 2 2 1 00403000 0 0 0 00 1 004001d8 00000000 00404000 1 00404000
1 004001d4 00000006 00000006 00000000 0 0 0 0 0 00000000 0 0 1 06 0 00000000 00000000 00000000 0 00000000
1 004001e0 00405000 00000000 00000000 1 0 2 2 0 00405000 0 0 0 00 1 004001e8 00000000 00405000 1 00405000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00000000 0 0 0 00 0 00000000 00000000 00000000 0 00000000
1 004001f0 7fffffff 00000001 00000000 0 0 0 0 0 00000000 0 0 1 07 1 80000000 00000001 7fffffff 0 00000000
